// ==== flist.f ====
hw/hft_pkg.sv
hw/price_stats.sv
hw/signal_generator.sv
hw/order_sizer.sv
hw/order_gate.sv
hw/order_compiler.sv
verification/order_compiler_tb.sv

// ==== hw/hft_pkg.sv ====
package hft_pkg;

    // Widths behind the shared vector types.
    localparam int PRICE_W = 32;
    localparam int QTY_W   = 16;

    // Price in ticks, also used for the deviation, the risk budget and word 2.
    typedef logic [PRICE_W-1:0] price_t;

    typedef logic [QTY_W-1:0] qty_t;

    // Net position in shares, signed so short positions are negative.
    typedef logic signed [PRICE_W-1:0] position_t;

    typedef logic [1:0] stock_id_t;

    // Integer multiplier applied to the deviation to form the band.
    typedef logic [7:0] thresh_t;

    // Word 1 is {12'b0, stock id, hold, side, quantity}.
    typedef logic [31:0] order_word_t;

    typedef enum logic {
        BUY  = 1'b0,
        SELL = 1'b1
    } side_t;

endpackage

// ==== hw/order_compiler.sv ====
`timescale 1ns/100ps

module order_compiler
    import hft_pkg::*;
#(
    parameter int SMOOTH_SHIFT = 4
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_tick_valid,
    input  price_t      i_price,
    input  price_t      i_best_bid,
    input  price_t      i_best_ask,
    input  thresh_t     i_threshold,
    input  qty_t        i_base_quantity,
    input  price_t      i_risk_budget,
    input  position_t   i_position_limit,
    input  stock_id_t   i_stock_id,
    output logic        o_order_valid,
    output order_word_t o_order_word_1,
    output order_word_t o_order_word_2,
    output position_t   o_position
);

    logic   stats_valid;
    price_t stats_price;
    price_t stats_bid;
    price_t stats_ask;
    price_t stats_mean;
    price_t stats_dev;

    logic   sig_valid;
    side_t  sig_side;
    logic   sig_hold;
    price_t sig_exec_price;
    price_t sig_dev;

    logic   size_valid;
    side_t  size_side;
    logic   size_hold;
    price_t size_exec_price;
    qty_t   size_quantity;

    price_stats #(
        .SMOOTH_SHIFT (SMOOTH_SHIFT)
    ) price_stats_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tick_valid (i_tick_valid),
        .i_price      (i_price),
        .i_best_bid   (i_best_bid),
        .i_best_ask   (i_best_ask),
        .o_valid      (stats_valid),
        .o_price      (stats_price),
        .o_best_bid   (stats_bid),
        .o_best_ask   (stats_ask),
        .o_mean       (stats_mean),
        .o_dev        (stats_dev)
    );

    signal_generator signal_generator_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (stats_valid),
        .i_price      (stats_price),
        .i_best_bid   (stats_bid),
        .i_best_ask   (stats_ask),
        .i_mean       (stats_mean),
        .i_dev        (stats_dev),
        .i_threshold  (i_threshold),
        .o_valid      (sig_valid),
        .o_side       (sig_side),
        .o_hold       (sig_hold),
        .o_exec_price (sig_exec_price),
        .o_dev        (sig_dev)
    );

    order_sizer order_sizer_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (sig_valid),
        .i_side          (sig_side),
        .i_hold          (sig_hold),
        .i_exec_price    (sig_exec_price),
        .i_dev           (sig_dev),
        .i_base_quantity (i_base_quantity),
        .i_risk_budget   (i_risk_budget),
        .o_valid         (size_valid),
        .o_side          (size_side),
        .o_hold          (size_hold),
        .o_exec_price    (size_exec_price),
        .o_quantity      (size_quantity)
    );

    order_gate order_gate_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (size_valid),
        .i_side           (size_side),
        .i_hold           (size_hold),
        .i_exec_price     (size_exec_price),
        .i_quantity       (size_quantity),
        .i_position_limit (i_position_limit),
        .i_stock_id       (i_stock_id),
        .o_order_valid    (o_order_valid),
        .o_order_word_1   (o_order_word_1),
        .o_order_word_2   (o_order_word_2),
        .o_position       (o_position)
    );

endmodule

// ==== hw/order_gate.sv ====
`timescale 1ns/100ps

module order_gate
    import hft_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  side_t       i_side,
    input  logic        i_hold,
    input  price_t      i_exec_price,
    input  qty_t        i_quantity,
    input  position_t   i_position_limit,
    input  stock_id_t   i_stock_id,
    output logic        o_order_valid,
    output order_word_t o_order_word_1,
    output order_word_t o_order_word_2,
    output position_t   o_position
);

    localparam int PAD_W = $bits(order_word_t) - QTY_W - $bits(stock_id_t) - 2;

    position_t   position_q;
    position_t   qty_ext;
    position_t   projected;
    position_t   proj_mag;
    logic        over_limit;
    logic        hold_bit;
    order_word_t word_1;

    always_comb begin
        qty_ext    = position_t'(i_quantity);
        projected  = (i_side == SELL) ? position_q - qty_ext : position_q + qty_ext;
        proj_mag   = projected[PRICE_W-1] ? -projected : projected;
        over_limit = proj_mag > i_position_limit;
        hold_bit   = i_hold | over_limit; // Either the signal or the risk check holds.
        word_1     = {{PAD_W{1'b0}}, i_stock_id, hold_bit, i_side, i_quantity};
    end

    // Every released order is assumed to fill in full.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_order_valid <= 1'b0;
            position_q    <= '0;
        end else begin
            o_order_valid <= i_valid;
            if (i_valid && !hold_bit) begin
                position_q <= projected;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_order_word_1 <= word_1;
            o_order_word_2 <= i_exec_price;
        end
    end

    assign o_position = position_q;

endmodule

// ==== hw/order_sizer.sv ====
`timescale 1ns/100ps

module order_sizer
    import hft_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  side_t  i_side,
    input  logic   i_hold,
    input  price_t i_exec_price,
    input  price_t i_dev,
    input  qty_t   i_base_quantity,
    input  price_t i_risk_budget,
    output logic   o_valid,
    output side_t  o_side,
    output logic   o_hold,
    output price_t o_exec_price,
    output qty_t   o_quantity
);

    localparam int DIV_W = PRICE_W + QTY_W;

    logic [DIV_W-1:0] divisor;
    logic [DIV_W-1:0] safe_divisor;
    logic [DIV_W-1:0] quotient;
    logic             saturate;

    always_comb begin
        divisor      = DIV_W'(i_dev) * DIV_W'(i_base_quantity);
        safe_divisor = (divisor == '0) ? DIV_W'(1) : divisor;
        quotient     = DIV_W'(i_risk_budget) / safe_divisor;
        saturate     = (divisor == '0) || (|quotient[DIV_W-1:QTY_W]);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_side       <= i_side;
            o_hold       <= i_hold;
            o_exec_price <= i_exec_price;
            o_quantity   <= saturate ? '1 : qty_t'(quotient); // Clamp to 65535.
        end
    end

endmodule

// ==== hw/price_stats.sv ====
`timescale 1ns/100ps

module price_stats
    import hft_pkg::*;
#(
    parameter int SMOOTH_SHIFT = 4
)
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_tick_valid,
    input  price_t i_price,
    input  price_t i_best_bid,
    input  price_t i_best_ask,
    output logic   o_valid,
    output price_t o_price,
    output price_t o_best_bid,
    output price_t o_best_ask,
    output price_t o_mean,
    output price_t o_dev
);

    logic                    first_tick;
    price_t                  mean_q;
    price_t                  dev_q;
    logic signed [PRICE_W:0] price_diff;
    price_t                  abs_diff;
    logic signed [PRICE_W:0] dev_diff;
    logic signed [PRICE_W:0] mean_next;
    logic signed [PRICE_W:0] dev_next;

    // One extra bit keeps the differences signed without overflow.
    always_comb begin
        price_diff = $signed({1'b0, i_price}) - $signed({1'b0, mean_q});
        abs_diff   = price_diff[PRICE_W] ? price_t'(-price_diff) : price_t'(price_diff);
        dev_diff   = $signed({1'b0, abs_diff}) - $signed({1'b0, dev_q});
        mean_next  = $signed({1'b0, mean_q}) + (price_diff >>> SMOOTH_SHIFT);
        dev_next   = $signed({1'b0, dev_q}) + (dev_diff >>> SMOOTH_SHIFT);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            first_tick <= 1'b1;
            mean_q     <= '0;
            dev_q      <= '0;
            o_valid    <= 1'b0;
        end else begin
            o_valid <= i_tick_valid;
            if (i_tick_valid) begin
                first_tick <= 1'b0;
                if (first_tick) begin
                    mean_q <= i_price; // Seed the mean, deviation stays zero.
                end else begin
                    mean_q <= price_t'(mean_next);
                    dev_q  <= price_t'(dev_next);
                end
            end
        end
    end

    // The statistics sent on are the ones from before this tick.
    always_ff @(posedge i_clk) begin
        if (i_tick_valid) begin
            o_price    <= i_price;
            o_best_bid <= i_best_bid;
            o_best_ask <= i_best_ask;
            o_mean     <= mean_q;
            o_dev      <= dev_q;
        end
    end

endmodule

// ==== hw/signal_generator.sv ====
`timescale 1ns/100ps

module signal_generator
    import hft_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_valid,
    input  price_t  i_price,
    input  price_t  i_best_bid,
    input  price_t  i_best_ask,
    input  price_t  i_mean,
    input  price_t  i_dev,
    input  thresh_t i_threshold,
    output logic    o_valid,
    output side_t   o_side,
    output logic    o_hold,
    output price_t  o_exec_price,
    output price_t  o_dev
);

    localparam int BAND_W = PRICE_W + $bits(thresh_t);
    localparam int EDGE_W = BAND_W + 1;

    logic [BAND_W-1:0] band;
    logic [EDGE_W-1:0] upper_edge;
    logic [BAND_W-1:0] lower_edge;
    logic              above_band;
    logic              below_band;

    always_comb begin
        band       = BAND_W'(i_threshold) * BAND_W'(i_dev);
        upper_edge = EDGE_W'(i_mean) + EDGE_W'(band);
        lower_edge = BAND_W'(i_mean) - band;
        above_band = EDGE_W'(i_price) > upper_edge;
        // No price can sit below a band wider than the mean.
        below_band = (band <= BAND_W'(i_mean)) && (BAND_W'(i_price) < lower_edge);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_dev <= i_dev;
            if (above_band) begin
                o_side       <= SELL; // Rich price, hit the bid.
                o_hold       <= 1'b0;
                o_exec_price <= i_best_bid;
            end else if (below_band) begin
                o_side       <= BUY; // Cheap price, lift the ask.
                o_hold       <= 1'b0;
                o_exec_price <= i_best_ask;
            end else begin
                o_side       <= BUY;
                o_hold       <= 1'b1;
                o_exec_price <= i_best_ask;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the order compiler testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module order_compiler_tb \
    -f flist.f \
    -o order_compiler_sim

./obj_dir/order_compiler_sim

// ==== verification/order_compiler_tb.sv ====
`timescale 1ns/100ps

module order_compiler_tb
    import hft_pkg::*;
();

    localparam int     SMOOTH_SHIFT    = 4;
    localparam int     TICKS_PER_PHASE = 60;
    localparam int     NUM_PHASES      = 4;
    localparam int     TIMEOUT_CYCLES  = TICKS_PER_PHASE * NUM_PHASES * 5 + 200;
    localparam price_t MID_PRICE       = 32'd100000;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_tick_valid;
    price_t      i_price;
    price_t      i_best_bid;
    price_t      i_best_ask;
    thresh_t     i_threshold;
    qty_t        i_base_quantity;
    price_t      i_risk_budget;
    position_t   i_position_limit;
    stock_id_t   i_stock_id;
    logic        o_order_valid;
    order_word_t o_order_word_1;
    order_word_t o_order_word_2;
    position_t   o_position;

    // Reference model state, kept wide so no step can wrap.
    longint      model_mean;
    longint      model_dev;
    longint      model_pos;
    bit          model_first;
    order_word_t exp_word1_q[$];
    order_word_t exp_word2_q[$];
    position_t   exp_pos_q[$];
    int          exp_cycle_q[$];
    logic [31:0] lfsr_state;
    price_t      walk_price;
    int          cycle_count;
    int          n_sell;
    int          n_buy;
    int          n_hold;

    order_compiler #(
        .SMOOTH_SHIFT (SMOOTH_SHIFT)
    ) order_compiler_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_tick_valid     (i_tick_valid),
        .i_price          (i_price),
        .i_best_bid       (i_best_bid),
        .i_best_ask       (i_best_ask),
        .i_threshold      (i_threshold),
        .i_base_quantity  (i_base_quantity),
        .i_risk_budget    (i_risk_budget),
        .i_position_limit (i_position_limit),
        .i_stock_id       (i_stock_id),
        .o_order_valid    (o_order_valid),
        .o_order_word_1   (o_order_word_1),
        .o_order_word_2   (o_order_word_2),
        .o_position       (o_position)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "Timeout");
        end
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits_out);
        int i;
        bits_out = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits_out   = {bits_out[30:0], lfsr_state[0]};
        end
    endtask

    task automatic compare_order_word(input string what, input order_word_t got,
                                      input order_word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "Order word mismatch");
        end
    endtask

    task automatic compare_position(input position_t got, input position_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: position is %0d, expected %0d", $time, got, exp);
            $display("Errors found");
            $fatal(1, "Position mismatch");
        end
    endtask

    task automatic check_latency(input int got);
        if (got != 4) begin
            $display("Fail at %0t: order latency is %0d cycles, expected 4", $time, got);
            $display("Errors found");
            $fatal(1, "Latency mismatch");
        end
    endtask

    // Applies the four stage rules to one tick and queues the expected order.
    task automatic model_tick(input price_t price, input price_t bid, input price_t ask);
        longint      p;
        longint      mean_old;
        longint      dev_old;
        longint      diff;
        longint      abs_diff;
        longint      band;
        longint      divisor;
        longint      quotient;
        longint      projected;
        longint      magnitude;
        side_t       side;
        logic        raw_hold;
        logic        hold;
        price_t      exec;
        qty_t        qty;
        order_word_t word1;
        p        = longint'(price);
        mean_old = model_mean;
        dev_old  = model_dev;
        if (model_first) begin
            model_mean  = p;
            model_first = 1'b0;
        end else begin
            diff       = p - mean_old;
            abs_diff   = (diff < 64'sd0) ? -diff : diff;
            model_mean = mean_old + (diff >>> SMOOTH_SHIFT);
            model_dev  = dev_old + ((abs_diff - dev_old) >>> SMOOTH_SHIFT);
        end
        band = longint'(i_threshold) * dev_old;
        if (p > mean_old + band) begin
            side     = SELL;
            raw_hold = 1'b0;
            exec     = bid;
            n_sell++;
        end else if (p < mean_old - band) begin
            side     = BUY;
            raw_hold = 1'b0;
            exec     = ask;
            n_buy++;
        end else begin
            side     = BUY;
            raw_hold = 1'b1;
            exec     = ask;
            n_hold++;
        end
        divisor = dev_old * longint'(i_base_quantity);
        if (divisor == 64'sd0) begin
            qty = 16'hFFFF;
        end else begin
            quotient = longint'(i_risk_budget) / divisor;
            qty      = (quotient > 64'sd65535) ? 16'hFFFF : qty_t'(quotient);
        end
        projected = (side == SELL) ? model_pos - longint'(qty) : model_pos + longint'(qty);
        magnitude = (projected < 64'sd0) ? -projected : projected;
        hold      = raw_hold || (magnitude > longint'(i_position_limit));
        if (!hold) begin
            model_pos = projected; // Released orders fill in full.
        end
        word1 = {12'b0, i_stock_id, hold, side, qty};
        exp_word1_q.push_back(word1);
        exp_word2_q.push_back(exec);
        exp_pos_q.push_back(position_t'(model_pos));
        exp_cycle_q.push_back(cycle_count);
    endtask

    // Random walk around the midpoint with an occasional large jump.
    task automatic next_tick(output price_t price, output price_t bid, output price_t ask);
        logic [31:0] r;
        logic [31:0] step;
        logic        down;
        take_bits(3, r);
        if (r[2:0] == 3'd0) begin
            take_bits(10, step);
        end else begin
            take_bits(5, step);
        end
        take_bits(1, r);
        down = r[0];
        if (walk_price > MID_PRICE + 32'd3000) begin
            down = 1'b1;
        end else if (walk_price < MID_PRICE - 32'd3000) begin
            down = 1'b0;
        end
        walk_price = down ? walk_price - step : walk_price + step;
        price      = walk_price;
        take_bits(3, r);
        bid = walk_price - 32'd1 - r;
        take_bits(3, r);
        ask = walk_price + 32'd1 + r;
    endtask

    task automatic run_phase(input thresh_t thr, input qty_t base, input price_t budget,
                             input position_t limit, input stock_id_t id,
                             input bit back_to_back);
        logic [31:0] r;
        price_t      p;
        price_t      b;
        price_t      a;
        int          t;
        i_threshold      = thr;
        i_base_quantity  = base;
        i_risk_budget    = budget;
        i_position_limit = limit;
        i_stock_id       = id;
        for (t = 0; t < TICKS_PER_PHASE; t++) begin
            next_tick(p, b, a);
            i_tick_valid = 1'b1;
            i_price      = p;
            i_best_bid   = b;
            i_best_ask   = a;
            model_tick(p, b, a);
            @(negedge i_clk);
            i_tick_valid = 1'b0;
            if (!back_to_back) begin
                take_bits(2, r);
                repeat (r[1:0]) @(negedge i_clk);
            end
        end
        // Configuration only changes with the pipeline empty.
        while (exp_word1_q.size() != 0) @(negedge i_clk);
    endtask

    always @(negedge i_clk) begin
        if (o_order_valid === 1'b1) begin
            if (exp_word1_q.size() == 0) begin
                $display("An order came out at %0t with no tick waiting for it", $time);
                $display("Errors found");
                $fatal(1, "Unexpected order");
            end else begin
                check_latency(cycle_count - exp_cycle_q.pop_front());
                compare_order_word("order word 1", o_order_word_1, exp_word1_q.pop_front());
                compare_order_word("order word 2", o_order_word_2, exp_word2_q.pop_front());
                compare_position(o_position, exp_pos_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] r;
        i_rst_n          = 1'b0;
        i_tick_valid     = 1'b0;
        i_price          = MID_PRICE;
        i_best_bid       = MID_PRICE;
        i_best_ask       = MID_PRICE;
        i_threshold      = 8'd1;
        i_base_quantity  = 16'd1;
        i_risk_budget    = 32'd0;
        i_position_limit = 32'sd0;
        i_stock_id       = 2'd0;
        lfsr_state       = 32'h57a4e570;
        walk_price       = MID_PRICE;
        model_mean       = 0;
        model_dev        = 0;
        model_pos        = 0;
        model_first      = 1'b1;
        cycle_count      = 0;
        n_sell           = 0;
        n_buy            = 0;
        n_hold           = 0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        run_phase(8'd1, 16'd100, 32'd40000, 32'sd25, 2'd3, 1'b0); // Tight limit.
        take_bits(4, r);
        run_phase(8'd2, qty_t'(r) + 16'd2, 32'd300000, 32'sd5000, 2'd1, 1'b0);
        run_phase(8'd1, 16'd8, 32'd1000000, 32'sd20000, 2'd0, 1'b1);
        run_phase(8'd2, 16'd1, 32'hFFFF_FFFF, 32'sd1000000, 2'd2, 1'b0); // Quotient overflow.

        repeat (8) @(negedge i_clk);
        if (n_sell == 0 || n_buy == 0 || n_hold == 0) begin
            $display("The price walk missed a signal class: %0d sell, %0d buy, %0d inside",
                     n_sell, n_buy, n_hold);
            $display("Errors found");
            $fatal(1, "Signal class not reached");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
